//--- compile.f
+incdir+include
src/rate_limiter_pkg.sv
src/rate_limiter_regs.sv
src/rate_limiter.sv
src/osnt_rate_limiter_top.sv
testbench/rate_limiter_assert.sv
testbench/rate_limiter_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= rate_limiter_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
RUN_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= Regression passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$($(SIM) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/rate_limiter_tb.sv
`include "rate_limiter_consts.svh"

module rate_limiter_tb
  import rate_limiter_pkg::*;
();

  localparam int NQ = `RL_NUM_QUEUES;

  typedef struct {
    int queue;
    int en;
    int gap;
    int npkt;
    int bpp;
    int low_pct;
    int flush;
  } row_t;

  // queue, limit_en, gap, packets, beats per packet, m_ready low percent, sw_rst first
  // Rows run four at a time, one per queue
  row_t rows [8] = '{
    '{0, 0, 0, 3, 4,  0, 0},
    '{1, 1, 5, 3, 3,  0, 0},
    '{2, 1, 2, 4, 2, 40, 0},
    '{3, 0, 9, 3, 3, 30, 0},
    '{0, 1, 3, 3, 1, 25, 0},
    '{1, 0, 0, 2, 5, 50, 0},
    '{2, 1, 4, 3, 2,  0, 1},
    '{3, 1, 1, 4, 3, 20, 0}
  };

  logic          axis_aclk;
  logic          rst;
  apb_req_t      apb_req;
  apb_rsp_t      apb_rsp;
  axis_beat_t    s_beat [NQ];
  logic [NQ-1:0] s_valid;
  logic [NQ-1:0] s_ready;
  axis_beat_t    m_beat [NQ];
  logic [NQ-1:0] m_valid;
  logic [NQ-1:0] m_ready;

  osnt_rate_limiter_top i_dut (.*);

  initial begin
    axis_aclk = 1'b0;
    forever #2 axis_aclk = ~axis_aclk;
  end

  task automatic halt_run();
    $display("Regression failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  task automatic check_reg(input string name, input reg_t got, input reg_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  task automatic check_gap(input string name, input gap_t got, input gap_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  function automatic addr_t reg_addr(input int q, input int ofs);
    return addr_t'(q * `RL_QUEUE_STRIDE + ofs);
  endfunction

  function automatic axis_beat_t make_beat(input logic last);
    axis_beat_t b;
    b.tdata = {$urandom, $urandom};
    b.tkeep = last ? keep_t'($urandom | 1) : '1;
    b.tuser = user_t'($urandom);
    b.tlast = last;
    return b;
  endfunction

  task automatic apb_xfer(input logic wr, input addr_t addr, input reg_t wdata,
                          output reg_t rdata, output logic slverr);
    int n;
    @(posedge axis_aclk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge axis_aclk);
    apb_req.penable <= 1'b1;
    n = 0;
    do begin
      @(negedge axis_aclk);
      n++;
    end while (!apb_rsp.pready && n < 16);
    if (!apb_rsp.pready) begin
      $display("APB access was never completed by pready");
      halt_run();
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge axis_aclk);
    apb_req <= '0;
  endtask

  task automatic reg_write(input addr_t addr, input reg_t data, input logic exp_err);
    reg_t rd;
    logic err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_flag("pslverr", err, exp_err);
  endtask

  task automatic reg_read(input addr_t addr, input reg_t exp_data, input logic exp_err);
    reg_t rd;
    logic err;
    apb_xfer(1'b0, addr, '0, rd, err);
    check_reg("prdata", rd, exp_data);
    check_flag("pslverr", err, exp_err);
  endtask

  task automatic configure(input int r);
    int q;
    q = rows[r].queue;
    // Flag registers keep bit 0 only
    reg_write(reg_addr(q, `RL_OFS_SW_RST), 32'hFFFF_FFFE, 1'b0);
    reg_write(reg_addr(q, `RL_OFS_LIMIT_EN), 32'h5A5A_0000 | reg_t'(rows[r].en), 1'b0);
    reg_write(reg_addr(q, `RL_OFS_GAP), reg_t'(rows[r].gap), 1'b0);
    reg_read(reg_addr(q, `RL_OFS_SW_RST), '0, 1'b0);
    reg_read(reg_addr(q, `RL_OFS_LIMIT_EN), reg_t'(rows[r].en), 1'b0);
    reg_read(reg_addr(q, `RL_OFS_GAP), reg_t'(rows[r].gap), 1'b0);
  endtask

  // Starts a long gap, then drains input under sw_rst
  task automatic flush_queue(input int q);
    reg_write(reg_addr(q, `RL_OFS_LIMIT_EN), 32'h1, 1'b0);
    reg_write(reg_addr(q, `RL_OFS_GAP), 32'd50, 1'b0);
    @(posedge axis_aclk);
    s_beat[q]  <= make_beat(1'b1);
    s_valid[q] <= 1'b1;
    m_ready[q] <= 1'b1;
    @(posedge axis_aclk);
    s_valid[q] <= 1'b0;
    reg_write(reg_addr(q, `RL_OFS_SW_RST), 32'h1, 1'b0);
    for (int i = 0; i < 6; i++) begin
      @(posedge axis_aclk);
      s_beat[q]  <= make_beat(i == 5);
      s_valid[q] <= 1'b1;
      @(negedge axis_aclk);
      check_flag("s_ready in flush", s_ready[q], 1'b1);
      check_flag("m_valid in flush", m_valid[q], 1'b0);
    end
    reg_write(reg_addr(q, `RL_OFS_SW_RST), 32'h0, 1'b0);
    @(posedge axis_aclk);
    s_valid[q] <= 1'b0;
  endtask

  task automatic run_stream(input int r);
    axis_beat_t sent_q [$];
    axis_beat_t cur;
    axis_beat_t want;
    gap_t       exp_gap;
    gap_t       gap_left;
    gap_t       idle;
    logic       measuring;
    int         q;
    int         total;
    int         sent;
    int         recv;
    int         cycles;
    q         = rows[r].queue;
    total     = rows[r].npkt * rows[r].bpp;
    exp_gap   = (rows[r].en != 0) ? gap_t'(rows[r].gap) : '0;
    gap_left  = '0;
    idle      = '0;
    measuring = 1'b0;
    sent      = 0;
    recv      = 0;
    cycles    = 0;
    if (rows[r].flush != 0) begin
      flush_queue(q);
      reg_write(reg_addr(q, `RL_OFS_LIMIT_EN), reg_t'(rows[r].en), 1'b0);
      reg_write(reg_addr(q, `RL_OFS_GAP), reg_t'(rows[r].gap), 1'b0);
    end
    cur = make_beat(rows[r].bpp == 1);
    while (recv < total || gap_left != '0) begin
      cycles++;
      if (cycles > 2000) begin
        $display("Queue %0d did not finish its packets in time", q);
        halt_run();
      end
      @(posedge axis_aclk);
      s_valid[q] <= (sent < total);
      s_beat[q]  <= cur;
      m_ready[q] <= (int'($urandom_range(99)) >= rows[r].low_pct);
      @(negedge axis_aclk);
      // Idle cycles from the tlast transfer to the first beat offered again
      if (measuring && m_valid[q]) begin
        check_gap($sformatf("gap[%0d]", q), idle, exp_gap);
        measuring = 1'b0;
      end
      // Model keeps the path open unless the queue is inside its gap
      check_flag($sformatf("m_valid[%0d]", q), m_valid[q], s_valid[q] && gap_left == '0);
      check_flag($sformatf("s_ready[%0d]", q), s_ready[q], m_ready[q] && gap_left == '0);
      idle++;
      if (gap_left != '0) begin
        gap_left--;
      end
      if (s_valid[q] && s_ready[q]) begin
        sent_q.push_back(cur);
        sent++;
        if (cur.tlast) begin
          gap_left  = exp_gap;
          idle      = '0;
          measuring = 1'b1;
        end
        cur = make_beat((sent % rows[r].bpp) == rows[r].bpp - 1);
      end
      if (m_valid[q] && m_ready[q]) begin
        want = sent_q.pop_front();
        check_beat($sformatf("m_beat[%0d]", q), m_beat[q], want);
        recv++;
      end
    end
    // Stop offering the last beat once the row is done
    @(posedge axis_aclk);
    s_valid[q] <= 1'b0;
  endtask

  initial begin
    int unsigned fails;
    void'($urandom(15));
    rst     = 1'b1;
    apb_req = '0;
    s_valid = '0;
    m_ready = '0;
    for (int q = 0; q < NQ; q++) begin
      s_beat[q] = '0;
    end
    repeat (8) @(posedge axis_aclk);
    rst <= 1'b0;
    @(negedge axis_aclk);
    check_flag("m_valid after reset", |m_valid, 1'b0);
    check_flag("s_ready after reset", |s_ready, 1'b0);
    check_flag("pslverr after reset", apb_rsp.pslverr, 1'b0);

    // Unaligned and unmapped addresses must leave limit_en untouched
    reg_write(8'h05, 32'hFFFF_FFFF, 1'b1);
    reg_write(8'h30, 32'hFFFF_FFFF, 1'b1);
    reg_read(8'h05, '0, 1'b1);
    reg_read(8'h30, '0, 1'b1);
    reg_read(reg_addr(0, `RL_OFS_LIMIT_EN), '0, 1'b0);

    for (int g = 0; g < 2; g++) begin
      for (int k = 0; k < NQ; k++) begin
        configure(g * NQ + k);
      end
      fork
        run_stream(g * NQ + 0);
        run_stream(g * NQ + 1);
        run_stream(g * NQ + 2);
        run_stream(g * NQ + 3);
      join
    end

    fails = i_dut.i_regs.i_rdy_assert.fail_cnt
          + i_dut.g_queue[0].i_limiter.i_lim_assert.fail_cnt
          + i_dut.g_queue[1].i_limiter.i_lim_assert.fail_cnt
          + i_dut.g_queue[2].i_limiter.i_lim_assert.fail_cnt
          + i_dut.g_queue[3].i_limiter.i_lim_assert.fail_cnt;
    if (fails != 0) begin
      $display("%0d assertion failures were flagged", fails);
      halt_run();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

//--- testbench/rate_limiter_assert.sv
module rate_limiter_assert
  import rate_limiter_pkg::*;
(
  input logic       axis_aclk,
  input logic       rst,
  input lim_state_t state,
  input logic       s_ready,
  input logic       m_valid,
  input logic       m_ready
);

  int unsigned fail_cnt = 0;

  // Output stays closed while a gap runs or the queue flushes
  quiet_outside_pass: assert property (
    @(posedge axis_aclk) disable iff (rst) (state != ST_PASS) |-> !m_valid
  ) else begin
    $error("m_valid high outside ST_PASS");
    fail_cnt++;
  end

  ready_follows_sink: assert property (
    @(posedge axis_aclk) disable iff (rst) (state == ST_PASS) |-> (s_ready == m_ready)
  ) else begin
    $error("s_ready differs from m_ready in ST_PASS");
    fail_cnt++;
  end

  quiet_in_reset: assert property (@(posedge axis_aclk) rst |-> !m_valid)
  else begin
    $error("m_valid high during reset");
    fail_cnt++;
  end

endmodule

module regs_ready_assert
  import rate_limiter_pkg::*;
(
  input logic     axis_aclk,
  input apb_rsp_t apb_rsp
);

  int unsigned fail_cnt = 0;

  // Bus never inserts wait states
  always_ready: assert property (@(posedge axis_aclk) apb_rsp.pready)
  else begin
    $error("pready low");
    fail_cnt++;
  end

endmodule

bind rate_limiter rate_limiter_assert i_lim_assert (.*);
bind rate_limiter_regs regs_ready_assert i_rdy_assert (.*);

//--- src/osnt_rate_limiter_top.sv
`include "rate_limiter_consts.svh"

module osnt_rate_limiter_top
  import rate_limiter_pkg::*;
(
  input  logic                      axis_aclk,
  input  logic                      rst,

  // Register bus
  input  apb_req_t                  apb_req,
  output apb_rsp_t                  apb_rsp,

  // Input streams, one per queue
  input  axis_beat_t                s_beat  [`RL_NUM_QUEUES],
  input  logic [`RL_NUM_QUEUES-1:0] s_valid,
  output logic [`RL_NUM_QUEUES-1:0] s_ready,

  // Output streams, one per queue
  output axis_beat_t                m_beat  [`RL_NUM_QUEUES],
  output logic [`RL_NUM_QUEUES-1:0] m_valid,
  input  logic [`RL_NUM_QUEUES-1:0] m_ready
);

  queue_cfg_t cfg [`RL_NUM_QUEUES];

  rate_limiter_regs i_regs (
    .axis_aclk (axis_aclk),
    .rst       (rst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .cfg       (cfg)
  );

  // One limiter per queue, each driven by its own register group
  for (genvar q = 0; q < `RL_NUM_QUEUES; q++) begin : g_queue
    rate_limiter i_limiter (
      .axis_aclk (axis_aclk),
      .rst       (rst),
      .cfg       (cfg[q]),
      .s_beat    (s_beat[q]),
      .s_valid   (s_valid[q]),
      .s_ready   (s_ready[q]),
      .m_beat    (m_beat[q]),
      .m_valid   (m_valid[q]),
      .m_ready   (m_ready[q])
    );
  end

endmodule

//--- src/rate_limiter.sv
module rate_limiter
  import rate_limiter_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       rst,
  input  queue_cfg_t cfg,
  input  axis_beat_t s_beat,
  input  logic       s_valid,
  output logic       s_ready,
  output axis_beat_t m_beat,
  output logic       m_valid,
  input  logic       m_ready
);

  lim_state_t state_q;
  lim_state_t state_d;
  lim_state_t state;
  gap_t       gap_cnt_q;
  gap_t       gap_cnt_d;
  logic       xfer;
  logic       pkt_end;
  logic       gap_start;

  // Software reset overrides the stored state in the same cycle;
  // the register then holds ST_FLUSH for one cycle after it drops
  assign state = cfg.sw_rst ? ST_FLUSH : state_q;

  // Beat handshake and end of packet
  assign xfer      = s_valid && s_ready;
  assign pkt_end   = xfer && s_beat.tlast;
  assign gap_start = pkt_end && cfg.limit_en && (cfg.gap != '0);

  // Payload is never stored and flows straight through
  assign m_beat = s_beat;

  // Stream path gating
  always_comb begin
    case (state)
      ST_PASS: begin
        m_valid = s_valid;
        s_ready = m_ready;
      end
      ST_GAP: begin
        m_valid = 1'b0;
        s_ready = 1'b0;
      end
      ST_FLUSH: begin
        // Sink everything, emit nothing
        m_valid = 1'b0;
        s_ready = 1'b1;
      end
      default: begin
        m_valid = 1'b0;
        s_ready = 1'b0;
      end
    endcase
  end

  // Next state and gap counter
  always_comb begin
    state_d   = state;
    gap_cnt_d = gap_cnt_q;
    case (state)
      ST_PASS: begin
        if (gap_start) begin
          state_d   = ST_GAP;
          gap_cnt_d = cfg.gap;
        end
      end
      ST_GAP: begin
        // Runs to completion even if limit_en is cleared meanwhile
        if (gap_cnt_q <= gap_t'(1)) begin
          state_d   = ST_PASS;
          gap_cnt_d = '0;
        end else begin
          gap_cnt_d = gap_cnt_q - gap_t'(1);
        end
      end
      ST_FLUSH: begin
        gap_cnt_d = '0;
        state_d   = cfg.sw_rst ? ST_FLUSH : ST_PASS;
      end
      default: begin
        state_d   = ST_PASS;
        gap_cnt_d = '0;
      end
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (rst) begin
      state_q   <= ST_PASS;
      gap_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      gap_cnt_q <= gap_cnt_d;
    end
  end

endmodule

//--- src/rate_limiter_regs.sv
`include "rate_limiter_consts.svh"

module rate_limiter_regs
  import rate_limiter_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       rst,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  output queue_cfg_t cfg [`RL_NUM_QUEUES]
);

  localparam int NQ     = `RL_NUM_QUEUES;
  localparam int QIDX_W = (NQ > 1) ? $clog2(NQ) : 1;

  logic              access;
  logic              wr_en;
  logic              hit;
  logic              hit_sw_rst;
  logic              hit_limit_en;
  logic              hit_gap;
  logic [QIDX_W-1:0] hit_q;
  reg_t              rd_data;

  // Access phase of an APB transfer
  assign access = apb_req.psel && apb_req.penable;

  // Address decode
  // Only exact word addresses match, so unaligned ones fall out as unmapped
  always_comb begin
    hit_sw_rst   = 1'b0;
    hit_limit_en = 1'b0;
    hit_gap      = 1'b0;
    hit_q        = '0;
    for (int q = 0; q < NQ; q++) begin
      if (apb_req.paddr == addr_t'(q * `RL_QUEUE_STRIDE + `RL_OFS_SW_RST)) begin
        hit_sw_rst = 1'b1;
        hit_q      = QIDX_W'(q);
      end
      if (apb_req.paddr == addr_t'(q * `RL_QUEUE_STRIDE + `RL_OFS_LIMIT_EN)) begin
        hit_limit_en = 1'b1;
        hit_q        = QIDX_W'(q);
      end
      if (apb_req.paddr == addr_t'(q * `RL_QUEUE_STRIDE + `RL_OFS_GAP)) begin
        hit_gap = 1'b1;
        hit_q   = QIDX_W'(q);
      end
    end
  end

  assign hit   = hit_sw_rst || hit_limit_en || hit_gap;
  assign wr_en = access && apb_req.pwrite && hit;

  // Read mux with the flag registers zero-extended
  always_comb begin
    rd_data = '0;
    if (hit_sw_rst) begin
      rd_data = reg_t'(cfg[hit_q].sw_rst);
    end
    if (hit_limit_en) begin
      rd_data = reg_t'(cfg[hit_q].limit_en);
    end
    if (hit_gap) begin
      rd_data = reg_t'(cfg[hit_q].gap);
    end
  end

  // No wait states on this bus
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.prdata  = access ? rd_data : '0;
  assign apb_rsp.pslverr = access && !hit;

  // Register storage
  // Writes land on the edge that closes the access cycle
  always_ff @(posedge axis_aclk) begin
    if (rst) begin
      for (int q = 0; q < NQ; q++) begin
        cfg[q] <= '0;
      end
    end else if (wr_en) begin
      if (hit_sw_rst) begin
        cfg[hit_q].sw_rst <= apb_req.pwdata[0];
      end
      if (hit_limit_en) begin
        cfg[hit_q].limit_en <= apb_req.pwdata[0];
      end
      if (hit_gap) begin
        cfg[hit_q].gap <= gap_t'(apb_req.pwdata);
      end
    end
  end

endmodule

//--- src/rate_limiter_pkg.sv
`include "rate_limiter_consts.svh"

package rate_limiter_pkg;

  // Stream payload fields
  typedef logic [`RL_DATA_W-1:0]   data_t;
  typedef logic [`RL_DATA_W/8-1:0] keep_t;
  typedef logic [`RL_USER_W-1:0]   user_t;

  // Register bus words
  typedef logic [`RL_REG_W-1:0]  reg_t;
  typedef logic [`RL_ADDR_W-1:0] addr_t;

  // Idle gap length in clock cycles
  typedef logic [`RL_REG_W-1:0] gap_t;

  // One stream beat
  typedef struct packed {
    data_t tdata;
    keep_t tkeep;
    user_t tuser;
    logic  tlast;
  } axis_beat_t;

  // Per-queue configuration as seen by a limiter
  typedef struct packed {
    logic sw_rst;
    logic limit_en;
    gap_t gap;
  } queue_cfg_t;

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    reg_t  pwdata;
  } apb_req_t;

  typedef struct packed {
    logic pready;
    reg_t prdata;
    logic pslverr;
  } apb_rsp_t;

  // Limiter FSM
  typedef enum logic [1:0] {
    ST_PASS  = 2'd0,
    ST_GAP   = 2'd1,
    ST_FLUSH = 2'd2
  } lim_state_t;

endpackage

//--- include/rate_limiter_consts.svh
`ifndef RATE_LIMITER_CONSTS_SVH
`define RATE_LIMITER_CONSTS_SVH

// Number of independent stream queues
`define RL_NUM_QUEUES 4

// Stream widths
`define RL_DATA_W 64
`define RL_USER_W 16

// Register bus widths
`define RL_REG_W  32
`define RL_ADDR_W 8

// Register map with one group of three words per queue
`define RL_QUEUE_STRIDE 12
`define RL_OFS_SW_RST   0
`define RL_OFS_LIMIT_EN 4
`define RL_OFS_GAP      8

`endif
